/* dnc_interface_input.txt */
// Hex words read in order: memory image for run 0, then for run 1 (16 words each),
// then per run the expected 8 read-key, 4 write-key and 2 strength words
// Run 0 image
1a01 1a02 1a03 1a04 2b01 2b02 2b03 2b04
3c01 3c02 3c03 3c04 4d01 4d02 5e0e 5e0f
// Run 1 image
a5f0 0f5a 1234 4321 beef cafe 0bad f00d
9001 9002 9003 9004 7777 8888 dead 0000
// Run 0 expected read keys
1a01 1a02 1a03 1a04 2b01 2b02 2b03 2b04
// Run 0 expected write key and strengths
3c01 3c02 3c03 3c04 4d01 4d02
// Run 1 expected read keys
a5f0 0f5a 1234 4321 beef cafe 0bad f00d
// Run 1 expected write key and strengths
9001 9002 9003 9004 7777 8888

/* dnc_interface.f */
dnc_interface_pkg.sv
dnc_interface_memory.sv
dnc_memory_arbiter.sv
dnc_read_keys.sv
dnc_write_key.sv
dnc_read_strengths.sv
dnc_interface_top.sv
dnc_interface_clock.sv
dnc_interface_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DNC interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module dnc_interface_tb -f dnc_interface.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/Vdnc_interface_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Result comes from the pass line in the output
if printf '%s\n' "$output" | grep -q "^TEST PASS$"; then
  exit 0
else
  exit 1
fi

/* dnc_interface_tb.sv */
`timescale 1ns/1ps

module dnc_interface_tb
  import dnc_interface_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic                 load_enable;
  logic [ADDR_SIZE-1:0] load_addr;
  logic [WORD_SIZE-1:0] load_data;
  logic [WORD_SIZE-1:0] key_out;
  logic                 key_out_i_enable;
  logic                 key_out_k_enable;
  logic                 keys_ready;
  logic [WORD_SIZE-1:0] write_key_out;
  logic                 write_key_enable;
  logic                 write_key_ready;
  logic [WORD_SIZE-1:0] strength_out;
  logic                 strength_enable;
  logic                 strengths_ready;

  // Two images then 14 expected words per run
  // Top bit marks an unloaded word
  logic [WORD_SIZE:0] data_words [2*MEM_DEPTH +
                                  2*(READ_HEADS*KEY_WORDS + KEY_WORDS + READ_HEADS)];

  // Collected streams
  logic [WORD_SIZE-1:0] key_words[$];
  bit                   row_flags[$];
  logic [WORD_SIZE-1:0] write_words[$];
  logic [WORD_SIZE-1:0] strength_words[$];

  int cycle_count = 0;
  int keys_ready_count;
  int write_ready_count;
  int strengths_ready_count;
  int keys_done_cycle;
  int write_done_cycle;
  int strengths_done_cycle;

  dnc_interface_clock clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  dnc_interface_top UUT (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .load_enable      (load_enable),
    .load_addr        (load_addr),
    .load_data        (load_data),
    .key_out          (key_out),
    .key_out_i_enable (key_out_i_enable),
    .key_out_k_enable (key_out_k_enable),
    .keys_ready       (keys_ready),
    .write_key_out    (write_key_out),
    .write_key_enable (write_key_enable),
    .write_key_ready  (write_key_ready),
    .strength_out     (strength_out),
    .strength_enable  (strength_enable),
    .strengths_ready  (strengths_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string test_name, input int expected, input int actual);
    if (expected != actual) begin
      $display("error: %s expected 'h%0h actual 'h%0h", test_name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  // Word of a run's memory image
  function automatic int image_word(input int run, input int addr);
    return int'(data_words[run*MEM_DEPTH + addr][WORD_SIZE-1:0]);
  endfunction

  // Expected stream word n in order keys, write key, strengths
  function automatic int expected_word(input int run, input int n);
    int base;
    base = 2*MEM_DEPTH + run*(READ_HEADS*KEY_WORDS + KEY_WORDS + READ_HEADS);
    return int'(data_words[base + n][WORD_SIZE-1:0]);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Monitors sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  always @(negedge CLK) begin
    if (!RST) begin
      if (key_out_k_enable) begin
        key_words.push_back(key_out);
        row_flags.push_back(key_out_i_enable);
      end else begin
        compare_value("row strobe without word strobe", 0, int'(key_out_i_enable));
      end
      if (write_key_enable) begin
        write_words.push_back(write_key_out);
      end
      if (strength_enable) begin
        strength_words.push_back(strength_out);
      end

      // Ready goes with the last strobe of its stream
      if (keys_ready) begin
        keys_ready_count++;
        keys_done_cycle = cycle_count;
        compare_value("keys ready with word strobe", 1, int'(key_out_k_enable));
        compare_value("keys ready on last word", READ_HEADS*KEY_WORDS, key_words.size());
      end
      if (write_key_ready) begin
        write_ready_count++;
        write_done_cycle = cycle_count;
        compare_value("write key ready with word strobe", 1, int'(write_key_enable));
        compare_value("write key ready on last word", KEY_WORDS, write_words.size());
      end
      if (strengths_ready) begin
        strengths_ready_count++;
        strengths_done_cycle = cycle_count;
        compare_value("strengths ready with word strobe", 1, int'(strength_enable));
        compare_value("strengths ready on last word", READ_HEADS, strength_words.size());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic load_image(input int run);
    for (int a = 0; a < MEM_DEPTH; a++) begin
      @(posedge CLK);
      load_enable <= 1'b1;
      load_addr   <= ADDR_SIZE'(a);
      load_data   <= WORD_SIZE'(image_word(run, a));
    end
    @(posedge CLK);
    load_enable <= 1'b0;
  endtask

  // File streams against the layout rule applied to the image
  task automatic check_file_layout(input int run);
    for (int i = 0; i < READ_HEADS; i++) begin
      for (int k = 0; k < KEY_WORDS; k++) begin
        compare_value($sformatf("run %0d file read key %0d.%0d", run, i, k),
                      image_word(run, READ_KEYS_BASE + i*KEY_WORDS + k),
                      expected_word(run, i*KEY_WORDS + k));
      end
    end
    for (int k = 0; k < KEY_WORDS; k++) begin
      compare_value($sformatf("run %0d file write key %0d", run, k),
                    image_word(run, WRITE_KEY_BASE + k),
                    expected_word(run, READ_HEADS*KEY_WORDS + k));
    end
    for (int i = 0; i < READ_HEADS; i++) begin
      compare_value($sformatf("run %0d file strength %0d", run, i),
                    image_word(run, READ_STRENGTHS_BASE + i),
                    expected_word(run, READ_HEADS*KEY_WORDS + KEY_WORDS + i));
    end
  endtask

  task automatic wait_for_streams_done();
    int waited;
    waited = 0;
    while (keys_ready_count == 0 || write_ready_count == 0 || strengths_ready_count == 0) begin
      @(posedge CLK);
      waited++;
      if (waited > 40) begin
        abort_run("streams did not finish within 40 cycles");
      end
    end
  endtask

  task automatic check_streams(input int run, input int start_cycle);
    int offset;
    compare_value($sformatf("run %0d read key count", run), READ_HEADS*KEY_WORDS,
                  key_words.size());
    for (int n = 0; n < READ_HEADS*KEY_WORDS; n++) begin
      compare_value($sformatf("run %0d read key word %0d", run, n),
                    expected_word(run, n), int'(key_words[n]));
      // Row strobe only on word 0 of each head
      compare_value($sformatf("run %0d row strobe %0d", run, n),
                    int'(n % KEY_WORDS == 0), int'(row_flags[n]));
    end
    offset = READ_HEADS*KEY_WORDS;
    compare_value($sformatf("run %0d write key count", run), KEY_WORDS, write_words.size());
    for (int n = 0; n < KEY_WORDS; n++) begin
      compare_value($sformatf("run %0d write key word %0d", run, n),
                    expected_word(run, offset + n), int'(write_words[n]));
    end
    offset = offset + KEY_WORDS;
    compare_value($sformatf("run %0d strength count", run), READ_HEADS, strength_words.size());
    for (int n = 0; n < READ_HEADS; n++) begin
      compare_value($sformatf("run %0d strength word %0d", run, n),
                    expected_word(run, offset + n), int'(strength_words[n]));
    end

    // One ready each and all inside the 27-cycle bound
    compare_value($sformatf("run %0d keys ready count", run), 1, keys_ready_count);
    compare_value($sformatf("run %0d write ready count", run), 1, write_ready_count);
    compare_value($sformatf("run %0d strengths ready count", run), 1, strengths_ready_count);
    compare_value($sformatf("run %0d keys in bound", run), 1,
                  int'(keys_done_cycle - start_cycle <= 27));
    compare_value($sformatf("run %0d write key in bound", run), 1,
                  int'(write_done_cycle - start_cycle <= 27));
    compare_value($sformatf("run %0d strengths in bound", run), 1,
                  int'(strengths_done_cycle - start_cycle <= 27));
  endtask

  task automatic run_vector(input int run);
    int gap;
    int start_cycle;
    load_image(run);
    check_file_layout(run);
    key_words.delete();
    row_flags.delete();
    write_words.delete();
    strength_words.delete();
    keys_ready_count      = 0;
    write_ready_count     = 0;
    strengths_ready_count = 0;

    // Idle gap before START
    gap = $urandom_range(5, 0);
    repeat (gap) @(posedge CLK);
    @(posedge CLK);
    start       <= 1'b1;
    start_cycle = cycle_count;
    @(posedge CLK);
    start <= 1'b0;

    // Extra START while all units are busy
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;

    wait_for_streams_done();
    // Room for any stray strobes
    repeat (8) @(posedge CLK);
    check_streams(run, start_cycle);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int waited;
    start       = 1'b0;
    load_enable = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    void'($urandom(32'hd690ba8b));

    for (int n = 0; n < $size(data_words); n++) begin
      data_words[n] = {1'b1, WORD_SIZE'(0)};
    end
    $readmemh("dnc_interface_input.txt", data_words);
    for (int n = 0; n < $size(data_words); n++) begin
      if (data_words[n][WORD_SIZE]) begin
        abort_run("data file missing or too short");
      end
    end

    waited = 0;
    while (RST) begin
      @(posedge CLK);
      waited++;
      if (waited > 40) begin
        abort_run("reset was never released");
      end
    end

    run_vector(0);
    run_vector(1);

    $display("TEST PASS");
    $finish;
  end

endmodule

/* dnc_interface_clock.sv */
`timescale 1ns/1ps

module dnc_interface_clock (
  output logic CLK,
  output logic RST
);

  // 20 ns period
  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  // Reset held over the first two rising edges
  initial begin
    RST = 1'b1;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

/* dnc_interface_top.sv */
`timescale 1ns/1ps

module dnc_interface_top
  import dnc_interface_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,

  // Host load port
  input  logic                 load_enable,
  input  logic [ADDR_SIZE-1:0] load_addr,
  input  logic [WORD_SIZE-1:0] load_data,

  // Read keys
  output logic [WORD_SIZE-1:0] key_out,
  output logic                 key_out_i_enable,
  output logic                 key_out_k_enable,
  output logic                 keys_ready,

  // Write key
  output logic [WORD_SIZE-1:0] write_key_out,
  output logic                 write_key_enable,
  output logic                 write_key_ready,

  // Read strengths
  output logic [WORD_SIZE-1:0] strength_out,
  output logic                 strength_enable,
  output logic                 strengths_ready
);

  //////////////////////////////////////////////////////////////////////
  // Wires
  //////////////////////////////////////////////////////////////////////

  // Memory read port
  logic                 mem_read_enable;
  logic [ADDR_SIZE-1:0] mem_read_addr;
  logic [WORD_SIZE-1:0] mem_read_data;

  // Unit requests, one bit per client
  logic                  keys_request;
  logic                  write_request;
  logic                  strengths_request;
  logic [ADDR_SIZE-1:0]  keys_addr;
  logic [ADDR_SIZE-1:0]  write_addr;
  logic [ADDR_SIZE-1:0]  strengths_addr;
  logic [REQUESTERS-1:0] grant;
  logic [REQUESTERS-1:0] return_strobe;
  logic [WORD_SIZE-1:0]  read_data;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  dnc_interface_memory memory (
    .CLK         (CLK),
    .RST         (RST),
    .load_enable (load_enable),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .read_enable (mem_read_enable),
    .read_addr   (mem_read_addr),
    .read_data   (mem_read_data)
  );

  dnc_memory_arbiter arbiter (
    .CLK                    (CLK),
    .RST                    (RST),
    .request                ({strengths_request, write_request, keys_request}),
    .request_addr_keys      (keys_addr),
    .request_addr_write     (write_addr),
    .request_addr_strengths (strengths_addr),
    .grant                  (grant),
    .read_enable            (mem_read_enable),
    .read_addr              (mem_read_addr),
    .read_data_mem          (mem_read_data),
    .return_strobe          (return_strobe),
    .read_data              (read_data)
  );

  // Client 0
  dnc_read_keys read_keys (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .request          (keys_request),
    .request_addr     (keys_addr),
    .grant            (grant[CLIENT_KEYS]),
    .return_strobe    (return_strobe[CLIENT_KEYS]),
    .read_data        (read_data),
    .key_out          (key_out),
    .key_out_i_enable (key_out_i_enable),
    .key_out_k_enable (key_out_k_enable),
    .ready            (keys_ready)
  );

  // Client 1
  dnc_write_key write_key (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .request          (write_request),
    .request_addr     (write_addr),
    .grant            (grant[CLIENT_WRITE]),
    .return_strobe    (return_strobe[CLIENT_WRITE]),
    .read_data        (read_data),
    .write_key_out    (write_key_out),
    .write_key_enable (write_key_enable),
    .ready            (write_key_ready)
  );

  // Client 2
  dnc_read_strengths read_strengths (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .request         (strengths_request),
    .request_addr    (strengths_addr),
    .grant           (grant[CLIENT_STRENGTH]),
    .return_strobe   (return_strobe[CLIENT_STRENGTH]),
    .read_data       (read_data),
    .strength_out    (strength_out),
    .strength_enable (strength_enable),
    .ready           (strengths_ready)
  );

endmodule

/* dnc_read_strengths.sv */
`timescale 1ns/1ps

module dnc_read_strengths
  import dnc_interface_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,

  // Arbiter side
  output logic                 request,
  output logic [ADDR_SIZE-1:0] request_addr,
  input  logic                 grant,
  input  logic                 return_strobe,
  input  logic [WORD_SIZE-1:0] read_data,

  // One strength per read head
  output logic [WORD_SIZE-1:0] strength_out,
  output logic                 strength_enable,
  output logic                 ready
);

  logic                       strengths_state;
  logic [HEAD_INDEX_SIZE-1:0] head_index;  // head i in flight

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  assign request_addr = ADDR_SIZE'(READ_STRENGTHS_BASE) + ADDR_SIZE'(head_index);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      strengths_state <= IDLE_STATE;
      head_index      <= '0;
      request         <= 1'b0;
      strength_out    <= '0;
      strength_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      strength_enable <= 1'b0;
      ready           <= 1'b0;

      case (strengths_state)
        IDLE_STATE : begin
          if (start) begin
            head_index      <= '0;
            request         <= 1'b1;
            strengths_state <= RUN_STATE;
          end
        end
        RUN_STATE : begin
          if (grant) begin
            request <= 1'b0;
          end
          if (return_strobe) begin
            strength_out    <= read_data;
            strength_enable <= 1'b1;
            // Done after head R-1
            if (head_index == HEAD_INDEX_SIZE'(READ_HEADS - 1)) begin
              ready           <= 1'b1;
              strengths_state <= IDLE_STATE;
            end else begin
              head_index <= head_index + 1'b1;
              request    <= 1'b1;
            end
          end
        end
        default : begin
          strengths_state <= IDLE_STATE;
        end
      endcase
    end
  end

endmodule

/* dnc_write_key.sv */
`timescale 1ns/1ps

module dnc_write_key
  import dnc_interface_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,

  // Arbiter side
  output logic                 request,
  output logic [ADDR_SIZE-1:0] request_addr,
  input  logic                 grant,
  input  logic                 return_strobe,
  input  logic [WORD_SIZE-1:0] read_data,

  // Write key stream
  output logic [WORD_SIZE-1:0] write_key_out,
  output logic                 write_key_enable,
  output logic                 ready
);

  logic                       write_key_state;
  logic [WORD_INDEX_SIZE-1:0] word_index;  // word k in flight

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  assign request_addr = ADDR_SIZE'(WRITE_KEY_BASE) + ADDR_SIZE'(word_index);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      write_key_state  <= IDLE_STATE;
      word_index       <= '0;
      request          <= 1'b0;
      write_key_out    <= '0;
      write_key_enable <= 1'b0;
      ready            <= 1'b0;
    end else begin
      write_key_enable <= 1'b0;
      ready            <= 1'b0;

      case (write_key_state)
        IDLE_STATE : begin
          if (start) begin
            word_index      <= '0;
            request         <= 1'b1;
            write_key_state <= RUN_STATE;
          end
        end
        RUN_STATE : begin
          if (grant) begin
            request <= 1'b0;
          end
          // Word back from memory
          if (return_strobe) begin
            write_key_out    <= read_data;
            write_key_enable <= 1'b1;
            if (word_index == WORD_INDEX_SIZE'(KEY_WORDS - 1)) begin
              ready           <= 1'b1;
              write_key_state <= IDLE_STATE;
            end else begin
              word_index <= word_index + 1'b1;
              request    <= 1'b1;
            end
          end
        end
        default : begin
          write_key_state <= IDLE_STATE;
        end
      endcase
    end
  end

endmodule

/* dnc_read_keys.sv */
`timescale 1ns/1ps

module dnc_read_keys
  import dnc_interface_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,

  // Arbiter side
  output logic                 request,
  output logic [ADDR_SIZE-1:0] request_addr,
  input  logic                 grant,
  input  logic                 return_strobe,
  input  logic [WORD_SIZE-1:0] read_data,

  // Key stream
  output logic [WORD_SIZE-1:0] key_out,
  output logic                 key_out_i_enable,  // row strobe, word 0 of each head
  output logic                 key_out_k_enable,  // word strobe
  output logic                 ready
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Controller
  logic read_keys_state;

  // Head i and word k of the word in flight
  logic [HEAD_INDEX_SIZE-1:0] index_i;
  logic [WORD_INDEX_SIZE-1:0] index_k;

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  // k(t;i;k) = k^(t;i;k), row-major in memory
  assign request_addr = ADDR_SIZE'(READ_KEYS_BASE)
                      + ADDR_SIZE'(index_i) * ADDR_SIZE'(KEY_WORDS)
                      + ADDR_SIZE'(index_k);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      read_keys_state  <= IDLE_STATE;
      index_i          <= '0;
      index_k          <= '0;
      request          <= 1'b0;
      key_out          <= '0;
      key_out_i_enable <= 1'b0;
      key_out_k_enable <= 1'b0;
      ready            <= 1'b0;
    end else begin
      // Strobes last one cycle
      key_out_i_enable <= 1'b0;
      key_out_k_enable <= 1'b0;
      ready            <= 1'b0;

      case (read_keys_state)
        IDLE_STATE : begin
          if (start) begin
            index_i         <= '0;
            index_k         <= '0;
            request         <= 1'b1;
            read_keys_state <= RUN_STATE;
          end
        end
        RUN_STATE : begin
          // Request drops once granted
          if (grant) begin
            request <= 1'b0;
          end

          if (return_strobe) begin
            key_out          <= read_data;
            key_out_k_enable <= 1'b1;
            key_out_i_enable <= (index_k == '0);

            if (index_k == WORD_INDEX_SIZE'(KEY_WORDS - 1)) begin
              if (index_i == HEAD_INDEX_SIZE'(READ_HEADS - 1)) begin
                // Last word of last head
                ready           <= 1'b1;
                read_keys_state <= IDLE_STATE;
              end else begin
                index_i <= index_i + 1'b1;
                index_k <= '0;
                request <= 1'b1;
              end
            end else begin
              index_k <= index_k + 1'b1;
              request <= 1'b1;
            end
          end
        end
        default : begin
          read_keys_state <= IDLE_STATE;
        end
      endcase
    end
  end

endmodule

/* dnc_memory_arbiter.sv */
`timescale 1ns/1ps

module dnc_memory_arbiter
  import dnc_interface_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,

  // Unit side
  input  logic [REQUESTERS-1:0] request,
  input  logic [ADDR_SIZE-1:0]  request_addr_keys,
  input  logic [ADDR_SIZE-1:0]  request_addr_write,
  input  logic [ADDR_SIZE-1:0]  request_addr_strengths,
  output logic [REQUESTERS-1:0] grant,

  // Memory side
  output logic                  read_enable,
  output logic [ADDR_SIZE-1:0]  read_addr,
  input  logic [WORD_SIZE-1:0]  read_data_mem,

  // Return path to all units
  output logic [REQUESTERS-1:0] return_strobe,
  output logic [WORD_SIZE-1:0]  read_data
);

  // Search starts after the client that won most recently
  logic [REQ_INDEX_SIZE-1:0] last_winner;
  logic [REQ_INDEX_SIZE-1:0] winner;

  //////////////////////////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////////////////////////

  always_comb begin : pick
    int candidate;
    grant  = '0;
    winner = last_winner;
    for (int n = 1; n <= REQUESTERS; n++) begin
      candidate = (int'(last_winner) + n) % REQUESTERS;
      if (grant == '0 && request[candidate]) begin
        grant[candidate] = 1'b1;
        winner           = REQ_INDEX_SIZE'(candidate);
      end
    end
  end

  // Address mux into the memory in the grant cycle
  always_comb begin
    read_addr = '0;
    if (grant[CLIENT_KEYS]) begin
      read_addr = request_addr_keys;
    end else if (grant[CLIENT_WRITE]) begin
      read_addr = request_addr_write;
    end else if (grant[CLIENT_STRENGTH]) begin
      read_addr = request_addr_strengths;
    end
  end

  assign read_enable = |grant;

  // Memory data goes to every unit and the strobe tells who owns it
  assign read_data = read_data_mem;

  //////////////////////////////////////////////////////////////////////
  // Pointer and return strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // First search after reset starts at client 0
      last_winner   <= REQ_INDEX_SIZE'(REQUESTERS - 1);
      return_strobe <= '0;
    end else begin
      if (read_enable) begin
        last_winner <= winner;
      end
      // Matches the one-cycle memory latency
      return_strobe <= grant;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // A client passed over twice in a row wins on its third cycle
  for (genvar c = 0; c < REQUESTERS; c++) begin : fairness
    client_served : assert property (
      @(posedge CLK) disable iff (RST)
      request[c] && $past(request[c] && !grant[c])
        && $past(request[c] && !grant[c], 2) |-> grant[c]
    );
  end

endmodule

/* dnc_interface_memory.sv */
`timescale 1ns/1ps

module dnc_interface_memory
  import dnc_interface_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,

  // Host load port
  input  logic                 load_enable,
  input  logic [ADDR_SIZE-1:0] load_addr,
  input  logic [WORD_SIZE-1:0] load_data,

  // Arbitrated read port
  input  logic                 read_enable,
  input  logic [ADDR_SIZE-1:0] read_addr,
  output logic [WORD_SIZE-1:0] read_data
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // One interface vector, word addressed
  logic [WORD_SIZE-1:0] mem_array [MEM_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Host write, only between runs
    if (load_enable) begin
      mem_array[load_addr] <= load_data;
    end

    // Registered read, data valid one cycle after the grant
    if (read_enable) begin
      read_data <= mem_array[read_addr];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Host must not load while the units are fetching
  load_read_collision : assert property (
    @(posedge CLK) disable iff (RST)
    !(load_enable && read_enable)
  );

endmodule

/* dnc_interface_pkg.sv */
package dnc_interface_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word and memory sizes
  //////////////////////////////////////////////////////////////////////

  // One interface-vector word
  localparam int WORD_SIZE = 16;

  // Interface-vector store
  localparam int MEM_DEPTH = 16;
  localparam int ADDR_SIZE = 4;

  //////////////////////////////////////////////////////////////////////
  // Head and key counts
  //////////////////////////////////////////////////////////////////////

  localparam int READ_HEADS = 2;  // R
  localparam int KEY_WORDS  = 4;  // W

  // Loop index widths
  localparam int HEAD_INDEX_SIZE = 1;
  localparam int WORD_INDEX_SIZE = 2;

  //////////////////////////////////////////////////////////////////////
  // Field layout in memory
  //////////////////////////////////////////////////////////////////////

  // Read keys row-major, head i word k at base + i*W + k
  localparam int READ_KEYS_BASE      = 0;
  localparam int WRITE_KEY_BASE      = READ_HEADS * KEY_WORDS;
  localparam int READ_STRENGTHS_BASE = READ_HEADS * KEY_WORDS + KEY_WORDS;

  //////////////////////////////////////////////////////////////////////
  // Arbiter clients and unit states
  //////////////////////////////////////////////////////////////////////

  // Client 0 read keys, 1 write key, 2 read strengths
  localparam int REQUESTERS      = 3;
  localparam int CLIENT_KEYS     = 0;
  localparam int CLIENT_WRITE    = 1;
  localparam int CLIENT_STRENGTH = 2;
  localparam int REQ_INDEX_SIZE  = 2;

  // Two-state unit controller
  localparam logic IDLE_STATE = 1'b0;
  localparam logic RUN_STATE  = 1'b1;

endpackage
